// File: Makefile
# Verilator build and run for the ooo_core testbench
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= ooo_core.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 3
) (
  output logic clock,
  output logic arst_n
);

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  // Release on a falling edge, away from the flops' sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
  end

endmodule

// File: bench/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;
  import core_pkg::*;

  localparam int clock_period = 100;
  localparam int total_insts  = 243;
  localparam int ready_always = 0;
  localparam int ready_held   = 1;
  localparam int ready_random = 2;

  logic     clock;
  logic     arst_n;
  logic     in_valid;
  logic     in_ready;
  op_e      in_op;
  reg_idx_t in_rd;
  reg_idx_t in_ra;
  reg_idx_t in_rb;
  word_t    in_imm;
  logic     ret_valid;
  logic     ret_ready;
  reg_idx_t ret_rd;
  word_t    ret_value;

  // Reference model state
  word_t       model_regs [num_regs];
  reg_idx_t    exp_rd [$];
  word_t       exp_value [$];
  int          errors;
  int          retired;
  int          ready_mode;
  logic [31:0] stim_lfsr;
  logic [31:0] stall_lfsr;

  tb_clock #(
    .period_ns    (clock_period),
    .reset_cycles (3)
  ) i_tb_clock (
    .clock  (clock),
    .arst_n (arst_n)
  );

  ooo_core i_ooo_core (
    .clock     (clock),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_op     (in_op),
    .in_rd     (in_rd),
    .in_ra     (in_ra),
    .in_rb     (in_rb),
    .in_imm    (in_imm),
    .ret_valid (ret_valid),
    .ret_ready (ret_ready),
    .ret_rd    (ret_rd),
    .ret_value (ret_value)
  );

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int nbits);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
      fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
      state = {state[30:0], fb};
      bits  = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input string what, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Program-order model of one accepted instruction
  task automatic model_inst(input op_e op, input reg_idx_t rd, input reg_idx_t ra,
                            input reg_idx_t rb, input word_t imm);
    word_t a;
    word_t b;
    word_t res;
    a = model_regs[ra];
    b = model_regs[rb];
    case (op)
      op_li:   res = imm;
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_xor:  res = a ^ b;
      default: res = a * b;
    endcase
    model_regs[rd] = res;
    exp_rd.push_back(rd);
    exp_value.push_back(res);
  endtask

  // Starts on a falling edge and returns on the one after acceptance
  task automatic send_inst(input op_e op, input reg_idx_t rd, input reg_idx_t ra,
                           input reg_idx_t rb, input word_t imm);
    in_valid = 1'b1;
    in_op    = op;
    in_rd    = rd;
    in_ra    = ra;
    in_rb    = rb;
    in_imm   = imm;
    while (!in_ready) @(negedge clock);
    model_inst(op, rd, ra, rb, imm);
    @(negedge clock);
    in_valid = 1'b0;
  endtask

  task automatic set_ready_mode(input int mode);
    @(posedge clock);
    ready_mode = mode;
    @(negedge clock);
  endtask

  task automatic wait_drain();
    while (exp_rd.size() != 0) @(posedge clock);
    @(negedge clock);
  endtask

  task automatic check_retire();
    reg_idx_t rd_e;
    word_t    value_e;
    if (exp_rd.size() == 0) begin
      errors++;
      $display("ERROR at %0t ns: r%0d retired with no instruction outstanding", $time, ret_rd);
    end else begin
      rd_e    = exp_rd.pop_front();
      value_e = exp_value.pop_front();
      check_reg("ret_rd", ret_rd, rd_e);
      check_word("ret_value", ret_value, value_e);
      retired++;
    end
  endtask

  // Retire monitor picks ret_ready and checks the result when a handshake is due
  always @(negedge clock) begin
    if (arst_n) begin
      case (ready_mode)
        ready_always: ret_ready = 1'b1;
        ready_held:   ret_ready = 1'b0;
        default:      ret_ready = (lfsr_take(stall_lfsr, 2) != 32'd0);
      endcase
      if (ret_valid && ret_ready) begin
        check_retire();
      end
    end
  end

  task automatic test_reset_and_li();
    check_flag("ret_valid after reset", ret_valid, 1'b0);
    check_flag("in_ready after reset", in_ready, 1'b1);
    for (int i = 0; i < 8; i++) begin
      send_inst(op_li, reg_idx_t'(i + 1), 4'd0, 4'd0, word_t'(i + 1) * 32'h1111_1111);
    end
    wait_drain();
  endtask

  task automatic test_dependency_chain();
    send_inst(op_li, 4'd1, 4'd0, 4'd0, 32'd5);
    send_inst(op_li, 4'd2, 4'd0, 4'd0, 32'd7);
    send_inst(op_add, 4'd3, 4'd1, 4'd2, '0);
    send_inst(op_sub, 4'd4, 4'd3, 4'd1, '0);
    send_inst(op_xor, 4'd5, 4'd4, 4'd3, '0);
    send_inst(op_add, 4'd6, 4'd5, 4'd5, '0);
    send_inst(op_sub, 4'd7, 4'd6, 4'd2, '0);
    send_inst(op_xor, 4'd1, 4'd7, 4'd1, '0);
    wait_drain();
  endtask

  task automatic test_mul_ordering();
    send_inst(op_li, 4'd8, 4'd0, 4'd0, 32'h0001_2345);
    send_inst(op_li, 4'd9, 4'd0, 4'd0, 32'h0006_789a);
    send_inst(op_mul, 4'd10, 4'd8, 4'd9, '0);
    // Independent add finishes before the product
    send_inst(op_add, 4'd11, 4'd1, 4'd2, '0);
    send_inst(op_add, 4'd12, 4'd10, 4'd11, '0);
    send_inst(op_li, 4'd13, 4'd0, 4'd0, 32'hdead_beef);
    send_inst(op_mul, 4'd14, 4'd13, 4'd13, '0);
    wait_drain();
  endtask

  task automatic test_back_pressure();
    logic saw_full;
    saw_full = 1'b0;
    set_ready_mode(ready_held);
    for (int i = 0; i < 20; i++) begin
      if (!in_ready && !saw_full) begin
        saw_full = 1'b1;
        set_ready_mode(ready_always);
      end
      if (i % 2 == 0) begin
        send_inst(op_li, reg_idx_t'(i % 16), 4'd0, 4'd0, word_t'(i * 3 + 1));
      end else begin
        send_inst(op_add, reg_idx_t'(i % 16), reg_idx_t'((i - 1) % 16),
                  reg_idx_t'(i % 16), '0);
      end
    end
    check_flag("in_ready low under back-pressure", saw_full, 1'b1);
    wait_drain();
  endtask

  task automatic test_random_program();
    logic [31:0] pick;
    op_e         op;
    reg_idx_t    rd;
    reg_idx_t    ra;
    reg_idx_t    rb;
    word_t       imm;
    set_ready_mode(ready_random);
    for (int i = 0; i < 200; i++) begin
      pick = lfsr_take(stim_lfsr, 3) % 5;
      op   = op_e'(pick[2:0]);
      rd   = reg_idx_t'(lfsr_take(stim_lfsr, 4));
      ra   = reg_idx_t'(lfsr_take(stim_lfsr, 4));
      rb   = reg_idx_t'(lfsr_take(stim_lfsr, 4));
      imm  = lfsr_take(stim_lfsr, 32);
      // Occasional idle cycle on the input
      if (lfsr_take(stim_lfsr, 2) == 32'd0) begin
        @(negedge clock);
      end
      send_inst(op, rd, ra, rb, imm);
    end
    wait_drain();
    set_ready_mode(ready_always);
  endtask

  initial begin
    in_valid   = 1'b0;
    in_op      = op_li;
    in_rd      = '0;
    in_ra      = '0;
    in_rb      = '0;
    in_imm     = '0;
    ret_ready  = 1'b1;
    ready_mode = ready_always;
    errors     = 0;
    retired    = 0;
    stim_lfsr  = 32'hc292;
    stall_lfsr = 32'hc292;
    for (int r = 0; r < num_regs; r++) begin
      model_regs[r] = '0;
    end
    @(posedge arst_n);
    @(negedge clock);
    test_reset_and_li();
    test_dependency_chain();
    test_mul_ordering();
    test_back_pressure();
    test_random_program();
    repeat (10) @(negedge clock);
    check_flag("ret_valid after last result", ret_valid, 1'b0);
    $display("%0d results retired, %0d errors", retired, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the instruction count
  initial begin
    #(total_insts * 20 * clock_period);
    $display("Timeout: the run did not finish in %0d cycles, %0d results still expected",
             total_insts * 20, exp_rd.size());
    $display("tests failed");
    $finish;
  end

endmodule

// File: hw/circ_buf.sv
`timescale 1ns/1ps

module circ_buf #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 4
) (
  input  logic     clock,
  input  logic     arst_n,
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data
);

  payload_t                   mem [depth];
  logic [$clog2(depth)-1:0]   rd_ptr_q;
  logic [$clog2(depth)-1:0]   wr_ptr_q;
  logic [$clog2(depth):0]     count_q;
  logic                       push;
  logic                       pop;

  assign push_ready = (count_q != depth);
  assign pop_valid  = (count_q != 0);
  assign push       = push_valid && push_ready;
  assign pop        = pop_valid && pop_ready;
  assign pop_data   = mem[rd_ptr_q];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count only moves when one side is idle
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr_q] <= push_data;
    end
  end

endmodule

// File: hw/core_pkg.sv
package core_pkg;

  localparam int num_regs = 16;

  typedef logic [31:0] word_t;

  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

  // Decoded operations
  typedef enum logic [2:0] {
    op_li  = 3'd0,
    op_add = 3'd1,
    op_sub = 3'd2,
    op_xor = 3'd3,
    op_mul = 3'd4
  } op_e;

  // Already decoded instruction as it enters the core
  typedef struct packed {
    op_e      op;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    word_t    imm;
  } inst_t;

endpackage

// File: hw/issue_alu.sv
`timescale 1ns/1ps

module issue_alu (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               inst_valid,
  input  core_pkg::inst_t    inst,
  output logic               inst_ready,
  output core_pkg::reg_idx_t rd_addr_a,
  output core_pkg::reg_idx_t rd_addr_b,
  input  core_pkg::word_t    rd_data_a,
  input  core_pkg::word_t    rd_data_b,
  rob_lookup_if.issue        lookup,
  output logic               mul_valid,
  output rob_pkg::rob_tag_t  mul_tag,
  output core_pkg::word_t    mul_a,
  output core_pkg::word_t    mul_b
);
  import core_pkg::*;
  import rob_pkg::*;

  // Register status table
  logic [num_regs-1:0] pend_q;
  rob_tag_t            tag_q [num_regs];

  logic     need_ops;
  logic     a_ok;
  logic     b_ok;
  word_t    a_val;
  word_t    b_val;
  logic     fire;
  word_t    alu_res;
  logic     alu_valid_q;
  rob_tag_t alu_tag_q;
  word_t    alu_value_q;

  assign rd_addr_a = inst.ra;
  assign rd_addr_b = inst.rb;
  assign lookup.a_tag = tag_q[inst.ra];
  assign lookup.b_tag = tag_q[inst.rb];

  // Pending operands come from the ROB once done
  assign a_ok  = !pend_q[inst.ra] || lookup.a_done;
  assign b_ok  = !pend_q[inst.rb] || lookup.b_done;
  assign a_val = pend_q[inst.ra] ? lookup.a_value : rd_data_a;
  assign b_val = pend_q[inst.rb] ? lookup.b_value : rd_data_b;

  assign need_ops   = (inst.op != op_li);
  assign fire       = inst_valid && !lookup.full && (!need_ops || (a_ok && b_ok));
  assign inst_ready = fire;

  assign lookup.alloc    = fire;
  assign lookup.alloc_rd = inst.rd;

  assign mul_valid = fire && (inst.op == op_mul);
  assign mul_tag   = lookup.alloc_tag;
  assign mul_a     = a_val;
  assign mul_b     = b_val;

  always_comb begin
    case (inst.op)
      op_li:   alu_res = inst.imm;
      op_add:  alu_res = a_val + b_val;
      op_sub:  alu_res = a_val - b_val;
      op_xor:  alu_res = a_val ^ b_val;
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      alu_valid_q <= 1'b0;
      pend_q      <= '0;
    end else begin
      alu_valid_q <= fire && (inst.op != op_mul);
      for (int r = 0; r < num_regs; r++) begin
        if (lookup.retire_valid && pend_q[r] && (tag_q[r] == lookup.retire_tag)) begin
          pend_q[r] <= 1'b0;
        end
      end
      // New producer overrides a retire of the old one
      if (fire) begin
        pend_q[inst.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fire) begin
      tag_q[inst.rd] <= lookup.alloc_tag;
      alu_tag_q      <= lookup.alloc_tag;
      alu_value_q    <= alu_res;
    end
  end

  assign lookup.alu_valid = alu_valid_q;
  assign lookup.alu_tag   = alu_tag_q;
  assign lookup.alu_value = alu_value_q;

endmodule

// File: hw/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              in_valid,
  input  rob_pkg::rob_tag_t in_tag,
  input  core_pkg::word_t   in_a,
  input  core_pkg::word_t   in_b,
  output logic              out_valid,
  output rob_pkg::rob_tag_t out_tag,
  output core_pkg::word_t   out_value
);
  import core_pkg::*;
  import rob_pkg::*;

  logic [mul_stages-1:0] vld_q;
  rob_tag_t              tag_q [mul_stages];

  // Stage 1 partial products on 16-bit halves
  word_t        p_ll_q;
  logic [15:0]  p_lh_q;
  logic [15:0]  p_hl_q;
  // Stage 2 folded cross terms
  word_t        low_q;
  logic [15:0]  cross_q;
  // Stage 3 product
  word_t        prod_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[mul_stages-2:0], in_valid};
    end
  end

  always_ff @(posedge clock) begin
    tag_q[0] <= in_tag;
    for (int s = 1; s < mul_stages; s++) begin
      tag_q[s] <= tag_q[s-1];
    end
    p_ll_q  <= in_a[15:0] * in_b[15:0];
    p_lh_q  <= 16'(in_a[15:0] * in_b[31:16]);
    p_hl_q  <= 16'(in_a[31:16] * in_b[15:0]);
    low_q   <= p_ll_q;
    cross_q <= p_lh_q + p_hl_q;
    prod_q  <= low_q + {cross_q, 16'h0000};
  end

  assign out_valid = vld_q[mul_stages-1];
  assign out_tag   = tag_q[mul_stages-1];
  assign out_value = prod_q;

endmodule

// File: hw/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  core_pkg::op_e      in_op,
  input  core_pkg::reg_idx_t in_rd,
  input  core_pkg::reg_idx_t in_ra,
  input  core_pkg::reg_idx_t in_rb,
  input  core_pkg::word_t    in_imm,
  output logic               ret_valid,
  input  logic               ret_ready,
  output core_pkg::reg_idx_t ret_rd,
  output core_pkg::word_t    ret_value
);
  import core_pkg::*;
  import rob_pkg::*;

  inst_t    in_inst;
  logic     iq_valid;
  logic     iq_ready;
  inst_t    iq_inst;
  reg_idx_t rf_addr_a;
  reg_idx_t rf_addr_b;
  word_t    rf_data_a;
  word_t    rf_data_b;
  logic     rf_wr_en;
  reg_idx_t rf_wr_addr;
  word_t    rf_wr_data;
  logic     mul_in_valid;
  rob_tag_t mul_in_tag;
  word_t    mul_a;
  word_t    mul_b;
  logic     mul_out_valid;
  rob_tag_t mul_out_tag;
  word_t    mul_out_value;
  logic     rq_push_valid;
  logic     rq_push_ready;
  retire_t  rq_push_data;
  retire_t  rq_pop_data;

  rob_lookup_if lookup ();

  assign in_inst = '{op: in_op, rd: in_rd, ra: in_ra, rb: in_rb, imm: in_imm};

  circ_buf #(
    .payload_t (inst_t),
    .depth     (queue_depth)
  ) i_inst_queue (
    .clock      (clock),
    .arst_n     (arst_n),
    .push_valid (in_valid),
    .push_ready (in_ready),
    .push_data  (in_inst),
    .pop_valid  (iq_valid),
    .pop_ready  (iq_ready),
    .pop_data   (iq_inst)
  );

  issue_alu i_issue_alu (
    .clock      (clock),
    .arst_n     (arst_n),
    .inst_valid (iq_valid),
    .inst       (iq_inst),
    .inst_ready (iq_ready),
    .rd_addr_a  (rf_addr_a),
    .rd_addr_b  (rf_addr_b),
    .rd_data_a  (rf_data_a),
    .rd_data_b  (rf_data_b),
    .lookup     (lookup.issue),
    .mul_valid  (mul_in_valid),
    .mul_tag    (mul_in_tag),
    .mul_a      (mul_a),
    .mul_b      (mul_b)
  );

  mul_unit i_mul_unit (
    .clock     (clock),
    .arst_n    (arst_n),
    .in_valid  (mul_in_valid),
    .in_tag    (mul_in_tag),
    .in_a      (mul_a),
    .in_b      (mul_b),
    .out_valid (mul_out_valid),
    .out_tag   (mul_out_tag),
    .out_value (mul_out_value)
  );

  rob i_rob (
    .clock     (clock),
    .arst_n    (arst_n),
    .lookup    (lookup.rob),
    .mul_valid (mul_out_valid),
    .mul_tag   (mul_out_tag),
    .mul_value (mul_out_value),
    .ret_valid (rq_push_valid),
    .ret_data  (rq_push_data),
    .ret_ready (rq_push_ready),
    .wr_en     (rf_wr_en),
    .wr_addr   (rf_wr_addr),
    .wr_data   (rf_wr_data)
  );

  rfile i_rfile (
    .clock     (clock),
    .arst_n    (arst_n),
    .rd_addr_a (rf_addr_a),
    .rd_addr_b (rf_addr_b),
    .rd_data_a (rf_data_a),
    .rd_data_b (rf_data_b),
    .wr_en     (rf_wr_en),
    .wr_addr   (rf_wr_addr),
    .wr_data   (rf_wr_data)
  );

  circ_buf #(
    .payload_t (retire_t),
    .depth     (queue_depth)
  ) i_retire_queue (
    .clock      (clock),
    .arst_n     (arst_n),
    .push_valid (rq_push_valid),
    .push_ready (rq_push_ready),
    .push_data  (rq_push_data),
    .pop_valid  (ret_valid),
    .pop_ready  (ret_ready),
    .pop_data   (rq_pop_data)
  );

  assign ret_rd    = rq_pop_data.rd;
  assign ret_value = rq_pop_data.value;

endmodule

// File: hw/rfile.sv
`timescale 1ns/1ps

module rfile (
  input  logic               clock,
  input  logic               arst_n,
  input  core_pkg::reg_idx_t rd_addr_a,
  input  core_pkg::reg_idx_t rd_addr_b,
  output core_pkg::word_t    rd_data_a,
  output core_pkg::word_t    rd_data_b,
  input  logic               wr_en,
  input  core_pkg::reg_idx_t wr_addr,
  input  core_pkg::word_t    wr_data
);
  import core_pkg::*;

  word_t regs_q [num_regs];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_addr] <= wr_data;
    end
  end

  // Write-first bypass
  assign rd_data_a = (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs_q[rd_addr_a];
  assign rd_data_b = (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs_q[rd_addr_b];

endmodule

// File: hw/rob.sv
`timescale 1ns/1ps

module rob (
  input  logic               clock,
  input  logic               arst_n,
  rob_lookup_if.rob          lookup,
  input  logic               mul_valid,
  input  rob_pkg::rob_tag_t  mul_tag,
  input  core_pkg::word_t    mul_value,
  output logic               ret_valid,
  output rob_pkg::retire_t   ret_data,
  input  logic               ret_ready,
  output logic               wr_en,
  output core_pkg::reg_idx_t wr_addr,
  output core_pkg::word_t    wr_data
);
  import rob_pkg::*;

  rob_entry_t rob_q [rob_depth];
  rob_tag_t   head_q;
  rob_tag_t   tail_q;
  logic       retire;

  // Entries are freed in order, so a busy tail means the ring is full
  assign lookup.alloc_tag = tail_q;
  assign lookup.full      = rob_q[tail_q].busy;

  assign lookup.a_done  = rob_q[lookup.a_tag].done;
  assign lookup.a_value = rob_q[lookup.a_tag].value;
  assign lookup.b_done  = rob_q[lookup.b_tag].done;
  assign lookup.b_value = rob_q[lookup.b_tag].value;

  // In-order retire from the head
  assign ret_valid = rob_q[head_q].busy && rob_q[head_q].done;
  assign retire    = ret_valid && ret_ready;
  assign ret_data  = '{rd: rob_q[head_q].rd, value: rob_q[head_q].value};

  assign wr_en   = retire;
  assign wr_addr = rob_q[head_q].rd;
  assign wr_data = rob_q[head_q].value;

  assign lookup.retire_valid = retire;
  assign lookup.retire_tag   = head_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_q <= '0;
      tail_q <= '0;
      for (int i = 0; i < rob_depth; i++) begin
        rob_q[i] <= '0;
      end
    end else begin
      if (lookup.alloc) begin
        rob_q[tail_q].busy <= 1'b1;
        rob_q[tail_q].done <= 1'b0;
        rob_q[tail_q].rd   <= lookup.alloc_rd;
        tail_q             <= tail_q + 1'b1;
      end
      // Both units may complete in the same cycle
      if (lookup.alu_valid) begin
        rob_q[lookup.alu_tag].done  <= 1'b1;
        rob_q[lookup.alu_tag].value <= lookup.alu_value;
      end
      if (mul_valid) begin
        rob_q[mul_tag].done  <= 1'b1;
        rob_q[mul_tag].value <= mul_value;
      end
      if (retire) begin
        rob_q[head_q].busy <= 1'b0;
        rob_q[head_q].done <= 1'b0;
        head_q             <= head_q + 1'b1;
      end
    end
  end

endmodule

// File: hw/rob_lookup_if.sv
`timescale 1ns/1ps

interface rob_lookup_if;
  import core_pkg::*;
  import rob_pkg::*;

  // Operand lookup
  rob_tag_t a_tag;
  rob_tag_t b_tag;
  logic     a_done;
  word_t    a_value;
  logic     b_done;
  word_t    b_value;

  // Allocation at the tail
  logic     alloc;
  reg_idx_t alloc_rd;
  rob_tag_t alloc_tag;
  logic     full;

  // ALU writeback and retire notice
  logic     alu_valid;
  rob_tag_t alu_tag;
  word_t    alu_value;
  logic     retire_valid;
  rob_tag_t retire_tag;

  modport issue (
    output a_tag, b_tag, alloc, alloc_rd, alu_valid, alu_tag, alu_value,
    input  a_done, a_value, b_done, b_value, alloc_tag, full, retire_valid, retire_tag
  );

  modport rob (
    input  a_tag, b_tag, alloc, alloc_rd, alu_valid, alu_tag, alu_value,
    output a_done, a_value, b_done, b_value, alloc_tag, full, retire_valid, retire_tag
  );

endinterface

// File: hw/rob_pkg.sv
package rob_pkg;

  localparam int rob_depth   = 8;
  localparam int queue_depth = 4;
  localparam int mul_stages  = 3;

  typedef logic [$clog2(rob_depth)-1:0] rob_tag_t;

  typedef struct packed {
    logic               busy;
    logic               done;
    core_pkg::reg_idx_t rd;
    core_pkg::word_t    value;
  } rob_entry_t;

  // Retire queue payload
  typedef struct packed {
    core_pkg::reg_idx_t rd;
    core_pkg::word_t    value;
  } retire_t;

endpackage

// File: ooo_core.f
hw/core_pkg.sv
hw/rob_pkg.sv
hw/rob_lookup_if.sv
hw/circ_buf.sv
hw/issue_alu.sv
hw/mul_unit.sv
hw/rob.sv
hw/rfile.sv
hw/ooo_core.sv
bench/tb_clock.sv
bench/tb_ooo_core.sv
